/* vlog.f */
verilog/mempool_addr_pkg.sv
verilog/mempool_ctrl_pkg.sv
verilog/host_req_decode.sv
verilog/l2_mem.sv
verilog/bootrom.sv
verilog/ctrl_registers.sv
verilog/rsp_queue.sv
verilog/mempool_system.sv
verification/clk_gen.sv
verification/mempool_system_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it; a $fatal in the run gives a failing status
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal \
       --top-module mempool_system_tb -f vlog.f \
  && ./obj_dir/Vmempool_system_tb \
  || { echo "mempool_system_tb: build or run did not pass"; exit 1; }

/* verification/mempool_system_tb.sv */
// MemPool system testbench
// Table-driven host accesses with random response back-pressure
`timescale 1ns/1ns

module mempool_system_tb;

  localparam int unsigned ResetCycles  = 10;
  localparam int unsigned CyclesPerRow = 40;
  localparam logic [31:0] EocAddr      =
    mempool_addr_pkg::CtrlBaseAddr + 32'(mempool_ctrl_pkg::EocOffset);

  typedef struct packed {
    logic                                   we;
    logic [mempool_addr_pkg::AddrWidth-1:0] addr;
    logic [mempool_addr_pkg::DataWidth-1:0] wdata;
    logic [mempool_addr_pkg::StrbWidth-1:0] strb;
    logic [mempool_addr_pkg::DataWidth-1:0] rdata; // Checked on reads and on errors
    logic                                   err;
    logic [mempool_ctrl_pkg::NumCores-1:0]  wake;  // Nonzero when a pulse is expected
  } row_t;

  logic                                   clk;
  logic                                   arst_n;
  logic                                   req_valid;
  logic                                   req_ready;
  logic [mempool_addr_pkg::AddrWidth-1:0] req_addr;
  logic                                   req_we;
  logic [mempool_addr_pkg::DataWidth-1:0] req_wdata;
  logic [mempool_addr_pkg::StrbWidth-1:0] req_strb;
  logic                                   rsp_valid;
  logic                                   rsp_ready = 1'b0;
  logic [mempool_addr_pkg::DataWidth-1:0] rsp_rdata;
  logic                                   rsp_err;
  logic [mempool_ctrl_pkg::NumCores-1:0]  wake_up;
  logic                                   eoc_valid;
  logic                                   busy;

  row_t                                  rows[$];
  logic [mempool_ctrl_pkg::NumCores-1:0] pulses[$]; // Wake-up values seen, one per cycle
  int                                    rsp_idx   = 0;
  int unsigned                           cycle_cnt = 0;
  logic [15:0]                           lfsr_q    = 16'd71;

  clk_gen #(.HalfPeriod(2), .ResetCycles(ResetCycles)) i_clk_gen (
    .clk_o   (clk   ),
    .arst_n_o(arst_n)
  );

  mempool_system DUT (
    .clk_i      (clk      ),
    .arst_n_i   (arst_n   ),
    .req_valid_i(req_valid),
    .req_ready_o(req_ready),
    .req_addr_i (req_addr ),
    .req_we_i   (req_we   ),
    .req_wdata_i(req_wdata),
    .req_strb_i (req_strb ),
    .rsp_valid_o(rsp_valid),
    .rsp_ready_i(rsp_ready),
    .rsp_rdata_o(rsp_rdata),
    .rsp_err_o  (rsp_err  ),
    .wake_up_o  (wake_up  ),
    .eoc_valid_o(eoc_valid),
    .busy_o     (busy     )
  );

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s got %h exp %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "value check failed on response %0d", rsp_idx);
    end
  endtask

  task automatic add_row(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] strb, input logic [31:0] rdata, input logic err,
                         input logic [3:0] wake);
    row_t r;
    r.we    = we;
    r.addr  = addr;
    r.wdata = wdata;
    r.strb  = strb;
    r.rdata = rdata;
    r.err   = err;
    r.wake  = wake;
    rows.push_back(r);
  endtask

  task automatic check_response();
    row_t                                  r;
    logic [mempool_ctrl_pkg::NumCores-1:0] pulse;
    if (rsp_idx >= rows.size()) begin
      $display("Simulation failed");
      $fatal(1, "A response arrived with no request outstanding");
    end else begin
      r = rows[rsp_idx];
      compare("rsp_err_o", 32'(rsp_err), 32'(r.err));
      compare("busy_o", 32'(busy), 32'd1); // This request is still in flight
      if (!r.we || r.err) compare("rsp_rdata_o", rsp_rdata, r.rdata);
      // EOC writes sit at least four rows apart, so no later one has landed yet
      if (r.we && (r.addr == EocAddr)) compare("eoc_valid_o", 32'(eoc_valid), 32'(r.wdata[0]));
      if (r.wake != '0) begin
        if (pulses.size() == 0) begin
          $display("Simulation failed");
          $fatal(1, "No wake-up pulse was seen for a WAKE_UP write");
        end else begin
          pulse = pulses.pop_front();
          compare("wake_up_o", 32'(pulse), 32'(r.wake));
        end
      end
      rsp_idx++;
    end
  endtask

  // Response back-pressure from one LFSR bit per cycle
  always @(posedge clk) begin
    lfsr_q    <= lfsr_next(lfsr_q);
    rsp_ready <= lfsr_q[0];
  end

  // Monitor that captures pulses before the response of the same cycle is checked
  always @(posedge clk) begin
    if (arst_n) begin
      if (wake_up != '0) pulses.push_back(wake_up);
      if (rsp_valid && rsp_ready) check_response();
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CyclesPerRow * rows.size() + ResetCycles) begin
      $display("Simulation failed");
      $fatal(1, "Timeout after %0d cycles with %0d responses received", cycle_cnt, rsp_idx);
    end
  end

  initial begin : stimulus
    row_t r;
    req_valid = 1'b0;
    req_addr  = '0;
    req_we    = 1'b0;
    req_wdata = '0;
    req_strb  = '0;

    // we, addr, wdata, strb, rdata, err, wake
    add_row(1'b1, 32'h8000_0000, 32'h1234_5678, 4'hF, 32'h0000_0000, 1'b0, 4'h0);
    add_row(1'b1, 32'h8000_0004, 32'hCAFE_F00D, 4'hF, 32'h0000_0000, 1'b0, 4'h0);
    add_row(1'b0, 32'h8000_0000, 32'h0000_0000, 4'h0, 32'h1234_5678, 1'b0, 4'h0);
    add_row(1'b0, 32'h8000_0004, 32'h0000_0000, 4'h0, 32'hCAFE_F00D, 1'b0, 4'h0);
    add_row(1'b1, 32'h8000_0004, 32'hAABB_CCDD, 4'h5, 32'h0000_0000, 1'b0, 4'h0);
    add_row(1'b0, 32'h8000_0004, 32'h0000_0000, 4'h0, 32'hCABB_F0DD, 1'b0, 4'h0);
    add_row(1'b1, 32'h8000_03FC, 32'hDEAD_BEEF, 4'hF, 32'h0000_0000, 1'b0, 4'h0);
    add_row(1'b0, 32'h8000_03FC, 32'h0000_0000, 4'h0, 32'hDEAD_BEEF, 1'b0, 4'h0);
    // Boot ROM
    add_row(1'b0, 32'hA000_0000, 32'h0000_0000, 4'h0, 32'hB007_0000, 1'b0, 4'h0);
    add_row(1'b0, 32'hA000_0014, 32'h0000_0000, 4'h0, 32'hB007_0005, 1'b0, 4'h0);
    add_row(1'b0, 32'hA000_003C, 32'h0000_0000, 4'h0, 32'hB007_000F, 1'b0, 4'h0);
    add_row(1'b1, 32'hA000_0008, 32'h1111_1111, 4'hF, 32'h0000_0000, 1'b1, 4'h0);
    // Control registers
    add_row(1'b1, 32'h4000_0000, 32'h0000_002B, 4'hF, 32'h0000_0000, 1'b0, 4'h0);
    add_row(1'b0, 32'h4000_0000, 32'h0000_0000, 4'h0, 32'h0000_002B, 1'b0, 4'h0);
    add_row(1'b1, 32'h4000_0004, 32'h0000_0005, 4'hF, 32'h0000_0000, 1'b0, 4'h5);
    add_row(1'b0, 32'h4000_0004, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0, 4'h0);
    add_row(1'b0, 32'h4000_0008, 32'h0000_0000, 4'h0, 32'h0000_0004, 1'b0, 4'h0);
    add_row(1'b1, 32'h4000_0008, 32'h0000_0007, 4'hF, 32'h0000_0000, 1'b1, 4'h0);
    add_row(1'b1, 32'h4000_0000, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0, 4'h0);
    add_row(1'b0, 32'h4000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0, 4'h0);
    add_row(1'b1, 32'h4000_0004, 32'hFFFF_FFFA, 4'hF, 32'h0000_0000, 1'b0, 4'hA);
    add_row(1'b1, 32'h4000_0004, 32'h0000_0003, 4'hF, 32'h0000_0000, 1'b0, 4'h3);
    // Unmapped addresses including the word just past each window
    add_row(1'b0, 32'h4000_000C, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b1, 4'h0);
    add_row(1'b0, 32'h0000_1000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b1, 4'h0);
    add_row(1'b1, 32'h8000_0400, 32'h5555_5555, 4'hF, 32'h0000_0000, 1'b1, 4'h0);
    add_row(1'b0, 32'hA000_0040, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b1, 4'h0);
    // Mixed reads back to back
    add_row(1'b0, 32'h8000_0000, 32'h0000_0000, 4'h0, 32'h1234_5678, 1'b0, 4'h0);
    add_row(1'b0, 32'h8000_0004, 32'h0000_0000, 4'h0, 32'hCABB_F0DD, 1'b0, 4'h0);
    add_row(1'b0, 32'hA000_0004, 32'h0000_0000, 4'h0, 32'hB007_0001, 1'b0, 4'h0);
    add_row(1'b0, 32'h4000_0008, 32'h0000_0000, 4'h0, 32'h0000_0004, 1'b0, 4'h0);

    wait (arst_n === 1'b1);
    @(posedge clk);
    compare("req_ready_o", 32'(req_ready), 32'd1);
    compare("rsp_valid_o", 32'(rsp_valid), 32'd0);
    compare("wake_up_o", 32'(wake_up), 32'd0);
    compare("eoc_valid_o", 32'(eoc_valid), 32'd0);
    compare("busy_o", 32'(busy), 32'd0);

    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      req_valid <= 1'b1;
      req_addr  <= r.addr;
      req_we    <= r.we;
      req_wdata <= r.wdata;
      req_strb  <= r.strb;
      @(posedge clk);
      while (!req_ready) @(posedge clk); // Held until the transfer edge
    end
    req_valid <= 1'b0;

    while (rsp_idx != rows.size()) @(posedge clk);
    @(posedge clk);
    compare("busy_o", 32'(busy), 32'd0);
    compare("rsp_valid_o", 32'(rsp_valid), 32'd0);
    if (pulses.size() != 0) begin
      $display("Simulation failed");
      $fatal(1, "A wake-up pulse appeared that no WAKE_UP write accounts for");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule : mempool_system_tb

/* verification/clk_gen.sv */
// Testbench clock and reset generator
// Free-running clock and an active-low reset held for a number of cycles
`timescale 1ns/1ns

module clk_gen #(
  parameter int unsigned HalfPeriod  = 2,
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // Released on a rising edge, after the reset cycles
  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule : clk_gen

/* verilog/mempool_system.sv */
// MemPool system wrapper
// Host request decoder, L2, boot ROM, control registers and in-order response queue
`timescale 1ns/1ns

module mempool_system (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  // Host request channel
  input  logic                                   req_valid_i,
  output logic                                   req_ready_o,
  input  logic [mempool_addr_pkg::AddrWidth-1:0] req_addr_i,
  input  logic                                   req_we_i,
  input  logic [mempool_addr_pkg::DataWidth-1:0] req_wdata_i,
  input  logic [mempool_addr_pkg::StrbWidth-1:0] req_strb_i,
  // Host response channel
  output logic                                   rsp_valid_o,
  input  logic                                   rsp_ready_i,
  output logic [mempool_addr_pkg::DataWidth-1:0] rsp_rdata_o,
  output logic                                   rsp_err_o,
  // Status
  output logic [mempool_ctrl_pkg::NumCores-1:0]  wake_up_o,
  output logic                                   eoc_valid_o,
  output logic                                   busy_o
);

  logic                                   acc_valid, acc_err, acc_we;
  mempool_addr_pkg::target_e              acc_tgt;
  logic                                   ctrl_req, l2_req, rom_req;
  logic [mempool_addr_pkg::AddrWidth-1:0] acc_addr;
  logic [mempool_addr_pkg::DataWidth-1:0] acc_wdata;
  logic [mempool_addr_pkg::StrbWidth-1:0] acc_strb;
  logic [mempool_addr_pkg::DataWidth-1:0] ctrl_rdata, l2_rdata, rom_rdata;
  logic                                   ctrl_err;
  logic                                   rsp_pop;

  host_req_decode i_host_req_decode (
    .clk_i      (clk_i      ),
    .arst_n_i   (arst_n_i   ),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .req_addr_i (req_addr_i ),
    .req_we_i   (req_we_i   ),
    .req_wdata_i(req_wdata_i),
    .req_strb_i (req_strb_i ),
    .rsp_pop_i  (rsp_pop    ),
    .acc_valid_o(acc_valid  ),
    .acc_tgt_o  (acc_tgt    ),
    .acc_err_o  (acc_err    ),
    .ctrl_req_o (ctrl_req   ),
    .l2_req_o   (l2_req     ),
    .rom_req_o  (rom_req    ),
    .acc_addr_o (acc_addr   ),
    .acc_we_o   (acc_we     ),
    .acc_wdata_o(acc_wdata  ),
    .acc_strb_o (acc_strb   ),
    .busy_o     (busy_o     )
  );

  l2_mem i_l2_mem (
    .clk_i  (clk_i    ),
    .req_i  (l2_req   ),
    .we_i   (acc_we   ),
    .addr_i (acc_addr ),
    .wdata_i(acc_wdata),
    .strb_i (acc_strb ),
    .rdata_o(l2_rdata )
  );

  bootrom i_bootrom (
    .clk_i  (clk_i    ),
    .req_i  (rom_req  ),
    .addr_i (acc_addr ),
    .rdata_o(rom_rdata)
  );

  ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i      ),
    .arst_n_i   (arst_n_i   ),
    .req_i      (ctrl_req   ),
    .we_i       (acc_we     ),
    .addr_i     (acc_addr   ),
    .wdata_i    (acc_wdata  ),
    .rdata_o    (ctrl_rdata ),
    .err_o      (ctrl_err   ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o)
  );

  rsp_queue i_rsp_queue (
    .clk_i       (clk_i      ),
    .arst_n_i    (arst_n_i   ),
    .acc_valid_i (acc_valid  ),
    .acc_tgt_i   (acc_tgt    ),
    .acc_err_i   (acc_err    ),
    .ctrl_rdata_i(ctrl_rdata ),
    .ctrl_err_i  (ctrl_err   ),
    .l2_rdata_i  (l2_rdata   ),
    .rom_rdata_i (rom_rdata  ),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o  ),
    .rsp_pop_o   (rsp_pop    )
  );

endmodule : mempool_system

/* verilog/rsp_queue.sv */
// Response queue
// Picks the answering target's data and returns responses to the host in order
`timescale 1ns/1ns

module rsp_queue (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  logic                                   acc_valid_i,
  input  mempool_addr_pkg::target_e              acc_tgt_i,
  input  logic                                   acc_err_i,
  input  logic [mempool_addr_pkg::DataWidth-1:0] ctrl_rdata_i,
  input  logic                                   ctrl_err_i,
  input  logic [mempool_addr_pkg::DataWidth-1:0] l2_rdata_i,
  input  logic [mempool_addr_pkg::DataWidth-1:0] rom_rdata_i,
  output logic                                   rsp_valid_o,
  input  logic                                   rsp_ready_i,
  output logic [mempool_addr_pkg::DataWidth-1:0] rsp_rdata_o,
  output logic                                   rsp_err_o,
  output logic                                   rsp_pop_o
);

  logic                                     push_q;   // Access stage delayed by one cycle
  mempool_addr_pkg::target_e                tgt_q;
  logic                                     acc_err_q;
  logic [mempool_addr_pkg::DataWidth-1:0]   new_rdata;
  logic                                     new_err;
  logic [mempool_addr_pkg::DataWidth-1:0]   data_q [mempool_addr_pkg::NumOutstanding];
  logic                                     err_q  [mempool_addr_pkg::NumOutstanding];
  logic [mempool_addr_pkg::PtrWidth-1:0]    wr_ptr_q, rd_ptr_q;
  logic [mempool_addr_pkg::CreditWidth-1:0] count_q;
  logic                                     empty, store;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) push_q <= 1'b0;
    else           push_q <= acc_valid_i;
  end

  always_ff @(posedge clk_i) begin
    tgt_q     <= acc_tgt_i;
    acc_err_q <= acc_err_i;
  end

  assign new_err = acc_err_q || ((tgt_q == mempool_addr_pkg::TgtCtrl) && ctrl_err_i);

  always_comb begin
    case (tgt_q)
      mempool_addr_pkg::TgtCtrl:    new_rdata = ctrl_rdata_i;
      mempool_addr_pkg::TgtL2:      new_rdata = l2_rdata_i;
      mempool_addr_pkg::TgtBootrom: new_rdata = rom_rdata_i;
      default:                      new_rdata = '0;
    endcase
    if (new_err) new_rdata = '0;
  end

  // Fall-through when empty, so a fresh response reaches the host at once
  assign empty       = (count_q == '0);
  assign rsp_valid_o = push_q || !empty;
  assign rsp_rdata_o = empty ? new_rdata : data_q[rd_ptr_q];
  assign rsp_err_o   = empty ? new_err : err_q[rd_ptr_q];
  assign rsp_pop_o   = rsp_valid_o && rsp_ready_i;
  assign store       = push_q && !(empty && rsp_pop_o);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (store) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rsp_pop_o && !empty) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + push_q - rsp_pop_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (store) begin
      data_q[wr_ptr_q] <= new_rdata;
      err_q[wr_ptr_q]  <= new_err;
    end
  end

  // Decoder credits keep the FIFO from overflowing
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(push_q && (count_q == mempool_addr_pkg::NumOutstanding)))
    else $error("push into full response queue");

endmodule : rsp_queue

/* verilog/ctrl_registers.sv */
// Control registers
// End-of-computation word, per-core wake-up pulses and the core count
`timescale 1ns/1ns

module ctrl_registers (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  logic                                   req_i,
  input  logic                                   we_i,
  input  logic [mempool_addr_pkg::AddrWidth-1:0] addr_i,
  input  logic [mempool_addr_pkg::DataWidth-1:0] wdata_i,
  output logic [mempool_addr_pkg::DataWidth-1:0] rdata_o,
  output logic                                   err_o,
  output logic [mempool_ctrl_pkg::NumCores-1:0]  wake_up_o,
  output logic                                   eoc_valid_o
);

  logic [mempool_ctrl_pkg::OffsetWidth-1:0] offset;
  mempool_ctrl_pkg::eoc_reg_u               eoc_q;
  logic [mempool_ctrl_pkg::NumCores-1:0]    wake_up_q;
  logic [mempool_addr_pkg::DataWidth-1:0]   rdata_d, rdata_q;
  logic                                     err_d, err_q;
  logic                                     eoc_wr, wake_wr;

  assign offset  = addr_i[mempool_ctrl_pkg::OffsetWidth-1:0];
  assign eoc_wr  = req_i && we_i && (offset == mempool_ctrl_pkg::EocOffset);
  assign wake_wr = req_i && we_i && (offset == mempool_ctrl_pkg::WakeUpOffset);

  // Read mux and access check
  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    case (offset)
      mempool_ctrl_pkg::EocOffset:      rdata_d = eoc_q.raw;
      mempool_ctrl_pkg::WakeUpOffset:   rdata_d = '0;       // Write-only pulse
      mempool_ctrl_pkg::NumCoresOffset: begin
        err_d   = we_i;                                     // Read-only
        rdata_d = we_i ? '0 : mempool_addr_pkg::DataWidth'(mempool_ctrl_pkg::NumCores);
      end
      default:                          err_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      eoc_q     <= '0;
      wake_up_q <= '0;
      err_q     <= 1'b0;
    end else begin
      if (eoc_wr) eoc_q.raw <= wdata_i;
      wake_up_q <= wake_wr ? wdata_i[mempool_ctrl_pkg::NumCores-1:0] : '0; // One-cycle pulse
      if (req_i) err_q <= err_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) rdata_q <= rdata_d;
  end

  assign rdata_o     = rdata_q;
  assign err_o       = err_q;
  assign wake_up_o   = wake_up_q;
  assign eoc_valid_o = eoc_q.fields.done;

endmodule : ctrl_registers

/* verilog/bootrom.sv */
// Boot ROM
// Registered lookup of the fixed boot image
`timescale 1ns/1ns

module bootrom (
  input  logic                                   clk_i,
  input  logic                                   req_i,
  input  logic [mempool_addr_pkg::AddrWidth-1:0] addr_i,
  output logic [mempool_addr_pkg::DataWidth-1:0] rdata_o
);

  logic [mempool_addr_pkg::BootromIdxWidth-1:0] idx;
  logic [mempool_addr_pkg::DataWidth-1:0]       rdata_q;

  assign idx = addr_i[mempool_addr_pkg::ByteOffset +: mempool_addr_pkg::BootromIdxWidth];

  // Image word i is the image base plus i
  always_ff @(posedge clk_i) begin
    if (req_i) rdata_q <= mempool_addr_pkg::BootromImageBase + idx;
  end

  assign rdata_o = rdata_q;

  // The decoder only strobes the ROM for addresses inside its window
  assert property (@(posedge clk_i)
    req_i |-> ((addr_i - mempool_addr_pkg::BootromBaseAddr) >> mempool_addr_pkg::ByteOffset)
              < mempool_addr_pkg::BootromNumWords)
    else $error("boot ROM index out of range");

endmodule : bootrom

/* verilog/l2_mem.sv */
// L2 scratch memory
// Single-port word storage with byte strobes and a one-cycle read
`timescale 1ns/1ns

module l2_mem (
  input  logic                                   clk_i,
  input  logic                                   req_i,
  input  logic                                   we_i,
  input  logic [mempool_addr_pkg::AddrWidth-1:0] addr_i,
  input  logic [mempool_addr_pkg::DataWidth-1:0] wdata_i,
  input  logic [mempool_addr_pkg::StrbWidth-1:0] strb_i,
  output logic [mempool_addr_pkg::DataWidth-1:0] rdata_o
);

  logic [mempool_addr_pkg::DataWidth-1:0]  mem_q [mempool_addr_pkg::L2NumWords];
  logic [mempool_addr_pkg::L2IdxWidth-1:0] idx;
  logic [mempool_addr_pkg::DataWidth-1:0]  rdata_q;

  assign idx = addr_i[mempool_addr_pkg::ByteOffset +: mempool_addr_pkg::L2IdxWidth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < mempool_addr_pkg::StrbWidth; b++) begin
          if (strb_i[b]) mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
      rdata_q <= mem_q[idx]; // Old word, also on a write
    end
  end

  assign rdata_o = rdata_q;

endmodule : l2_mem

/* verilog/host_req_decode.sv */
// Host request decoder
// Registers host requests into the shared access stage and keeps in-flight credits
`timescale 1ns/1ns

module host_req_decode (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  logic                                   req_valid_i,
  output logic                                   req_ready_o,
  input  logic [mempool_addr_pkg::AddrWidth-1:0] req_addr_i,
  input  logic                                   req_we_i,
  input  logic [mempool_addr_pkg::DataWidth-1:0] req_wdata_i,
  input  logic [mempool_addr_pkg::StrbWidth-1:0] req_strb_i,
  input  logic                                   rsp_pop_i,
  output logic                                   acc_valid_o,
  output mempool_addr_pkg::target_e              acc_tgt_o,
  output logic                                   acc_err_o,
  output logic                                   ctrl_req_o,
  output logic                                   l2_req_o,
  output logic                                   rom_req_o,
  output logic [mempool_addr_pkg::AddrWidth-1:0] acc_addr_o,
  output logic                                   acc_we_o,
  output logic [mempool_addr_pkg::DataWidth-1:0] acc_wdata_o,
  output logic [mempool_addr_pkg::StrbWidth-1:0] acc_strb_o,
  output logic                                   busy_o
);

  mempool_addr_pkg::target_e tgt;
  logic                                     err;
  logic                                     accept;
  logic [mempool_addr_pkg::CreditWidth-1:0] credit_q;

  function automatic logic in_window(logic [31:0] addr, logic [31:0] base, logic [31:0] size);
    return (addr >= base) && (addr < base + size);
  endfunction

  always_comb begin
    if (in_window(req_addr_i, mempool_addr_pkg::CtrlBaseAddr, mempool_addr_pkg::CtrlWindowBytes))
      tgt = mempool_addr_pkg::TgtCtrl;
    else if (in_window(req_addr_i, mempool_addr_pkg::L2BaseAddr,
                       mempool_addr_pkg::L2NumWords * mempool_addr_pkg::StrbWidth))
      tgt = mempool_addr_pkg::TgtL2;
    else if (in_window(req_addr_i, mempool_addr_pkg::BootromBaseAddr,
                       mempool_addr_pkg::BootromNumWords * mempool_addr_pkg::StrbWidth))
      tgt = mempool_addr_pkg::TgtBootrom;
    else
      tgt = mempool_addr_pkg::TgtNone;
  end

  // Unmapped or a write to the ROM
  assign err = (tgt == mempool_addr_pkg::TgtNone) ||
               ((tgt == mempool_addr_pkg::TgtBootrom) && req_we_i);

  assign req_ready_o = (credit_q != mempool_addr_pkg::NumOutstanding);
  assign accept      = req_valid_i && req_ready_o;
  assign busy_o      = (credit_q != '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc_valid_o <= 1'b0;
      ctrl_req_o  <= 1'b0;
      l2_req_o    <= 1'b0;
      rom_req_o   <= 1'b0;
    end else begin
      acc_valid_o <= accept;
      ctrl_req_o  <= accept && !err && (tgt == mempool_addr_pkg::TgtCtrl);
      l2_req_o    <= accept && !err && (tgt == mempool_addr_pkg::TgtL2);
      rom_req_o   <= accept && !err && (tgt == mempool_addr_pkg::TgtBootrom);
    end
  end

  // Payload of the access stage
  always_ff @(posedge clk_i) begin
    if (accept) begin
      acc_tgt_o   <= tgt;
      acc_err_o   <= err;
      acc_addr_o  <= req_addr_i;
      acc_we_o    <= req_we_i;
      acc_wdata_o <= req_wdata_i;
      acc_strb_o  <= req_strb_i;
    end
  end

  // One credit per request between acceptance and response pop
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) credit_q <= '0;
    else if (accept && !rsp_pop_i) credit_q <= credit_q + 1'b1;
    else if (!accept && rsp_pop_i) credit_q <= credit_q - 1'b1;
  end

  // Pops come from rsp_queue and must never outnumber accepted requests
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    credit_q <= mempool_addr_pkg::NumOutstanding)
    else $error("credit count above limit");

endmodule : host_req_decode

/* verilog/mempool_ctrl_pkg.sv */
// MemPool control register definitions
// Register offsets, core count and the EOC register layout
package mempool_ctrl_pkg;

  localparam int unsigned NumCores = 4;

  // Offsets inside the 64-byte control window
  localparam int unsigned OffsetWidth = 6;
  localparam logic [OffsetWidth-1:0] EocOffset      = 6'h00;
  localparam logic [OffsetWidth-1:0] WakeUpOffset   = 6'h04;
  localparam logic [OffsetWidth-1:0] NumCoresOffset = 6'h08;

  // EOC word, seen raw by the host and as fields by the hardware
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [30:0] exit_code;
      logic        done;      // Bit 0, drives eoc_valid_o
    } fields;
  } eoc_reg_u;

endpackage : mempool_ctrl_pkg

/* verilog/mempool_addr_pkg.sv */
// MemPool system address map
// Bus widths, target windows and in-flight limits for the host datapath
package mempool_addr_pkg;

  // Bus widths
  localparam int unsigned DataWidth  = 32;
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned StrbWidth  = DataWidth / 8;
  localparam int unsigned ByteOffset = $clog2(StrbWidth); // Address bits below the word index

  // L2 scratch memory, 1 KiB
  localparam logic [31:0] L2BaseAddr = 32'h8000_0000;
  localparam int unsigned L2NumWords = 256;
  localparam int unsigned L2IdxWidth = $clog2(L2NumWords);

  // Boot ROM
  localparam logic [31:0] BootromBaseAddr  = 32'hA000_0000;
  localparam int unsigned BootromNumWords  = 16;
  localparam int unsigned BootromIdxWidth  = $clog2(BootromNumWords);
  localparam logic [31:0] BootromImageBase = 32'hB007_0000; // Word i holds base plus i

  // Control register window
  localparam logic [31:0] CtrlBaseAddr    = 32'h4000_0000;
  localparam int unsigned CtrlWindowBytes = 64;

  // In-flight tracking, shared by the credit counter and the response FIFO
  localparam int unsigned NumOutstanding = 4;
  localparam int unsigned CreditWidth    = $clog2(NumOutstanding + 1);
  localparam int unsigned PtrWidth       = $clog2(NumOutstanding);

  typedef enum logic [1:0] {
    TgtCtrl,
    TgtL2,
    TgtBootrom,
    TgtNone     // Unmapped address
  } target_e;

endpackage : mempool_addr_pkg
